//--- design/axiPkg.sv
package axiPkg;

    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;
    localparam int IdWidth   = 4;
    localparam int StrbWidth = DataWidth / 8;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [DataWidth-1:0] wordT;
    typedef logic [StrbWidth-1:0] strobeT;
    typedef logic [IdWidth-1:0]   idT;
    typedef logic [3:0]           lenT;    // Beats minus one.
    typedef logic [2:0]           sizeT;
    typedef logic [1:0]           burstT;

    // Address channel payload, shared by AR and AW.
    typedef struct packed {
        idT    id;
        addrT  addr;
        lenT   len;
        sizeT  size;
        burstT burst;
    } axT;

    typedef struct packed {
        wordT   data;
        strobeT strobe;
        logic   last;
    } wBeatT;

    localparam idT IdInst = idT'(0);
    localparam idT IdData = idT'(1);

    localparam lenT LenLine   = lenT'(3);    // 4 beats.
    localparam lenT LenSingle = lenT'(0);

    localparam sizeT SizeWord = 3'b010;      // 4 bytes per beat.

    localparam burstT BurstIncr = 2'b01;
    localparam burstT BurstWrap = 2'b10;

endpackage

//--- design/cpuPkg.sv
package cpuPkg;

    import axiPkg::addrT;
    import axiPkg::wordT;
    import axiPkg::strobeT;

    localparam int BeatsPerLine = 4;
    localparam int LineBytes    = 16;
    localparam int BeatIdxBits  = $clog2(BeatsPerLine);

    // Instruction cache line, beat 0 in the low word.
    typedef logic [BeatsPerLine*$bits(wordT)-1:0] lineT;

    typedef struct packed {
        addrT pc;
    } instReqT;

    typedef struct packed {
        addrT   addr;
        wordT   wData;
        strobeT strobe;
        logic   writeEn;
    } dataReqT;

endpackage

//--- design/reqSlot.sv
`timescale 1ns/100ps

module reqSlot #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,

    input  logic    reqValid,
    input  payloadT reqIn,
    output logic    reqReady,

    input  logic    releasePulse,   // From the owning engine.
    output logic    busy,
    output payloadT held
);

    logic capture;

    assign capture  = reqValid && reqReady;
    assign reqReady = ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (capture) begin
            busy <= 1'b1;
        end else if (releasePulse) begin
            busy <= 1'b0;
        end
    end

    // Payload stays put until the slot is freed.
    always_ff @(posedge clk) begin
        if (capture) begin
            held <= reqIn;
        end
    end

endmodule

//--- design/readEngine.sv
`timescale 1ns/100ps

module readEngine import axiPkg::*, cpuPkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    instBusy,
    input  instReqT instHeld,
    output logic    instRelease,

    input  logic    dataBusy,
    input  dataReqT dataHeld,
    output logic    dataRelease,

    output logic    arValid,
    output axT      ar,
    input  logic    arReady,

    input  logic    rValid,
    input  wordT    rData,
    input  logic    rLast,
    output logic    rReady,

    output logic    instRespValid,
    output lineT    instLine,
    input  logic    instRespReady,

    output logic    dataRespValid,
    output wordT    dataRdata,
    input  logic    dataRespReady
);

    typedef enum logic [1:0] {
        RIdle,
        RInstBeats,
        RDataBeat
    } rStateT;

    rStateT state;
    rStateT stateNext;

    logic dataRd;
    logic beatTaken;
    logic [BeatIdxBits-1:0] beatIdx;

    // Lower words of the line; the last beat goes straight to the output.
    wordT [BeatsPerLine-2:0] asmLine;

    assign dataRd  = dataBusy && !dataHeld.writeEn;   // Writes belong to the write engine.
    assign arValid = (state == RIdle) && (dataRd || instBusy);

    // Data read wins over a fetch.
    always_comb begin
        ar.size = SizeWord;
        if (dataRd) begin
            ar.id    = IdData;
            ar.addr  = dataHeld.addr;
            ar.len   = LenSingle;
            ar.burst = BurstIncr;
        end else begin
            ar.id    = IdInst;
            ar.addr  = instHeld.pc & ~addrT'(LineBytes - 1);
            ar.len   = LenLine;
            ar.burst = BurstWrap;
        end
    end

    always_comb begin
        rReady        = 1'b0;
        instRespValid = 1'b0;
        dataRespValid = 1'b0;
        case (state)
            RInstBeats: begin
                instRespValid = rValid && rLast;
                rReady        = rLast ? instRespReady : 1'b1;   // Hold the last beat.
            end
            RDataBeat: begin
                dataRespValid = rValid;
                rReady        = dataRespReady;
            end
            default: begin
                rReady = 1'b0;
            end
        endcase
    end

    assign instLine    = {rData, asmLine};
    assign dataRdata   = rData;
    assign instRelease = instRespValid && instRespReady;
    assign dataRelease = dataRespValid && dataRespReady;
    assign beatTaken   = (state == RInstBeats) && rValid && rReady;

    always_comb begin
        stateNext = state;
        case (state)
            RIdle: begin
                if (arValid && arReady) begin
                    stateNext = dataRd ? RDataBeat : RInstBeats;
                end
            end
            RInstBeats: begin
                if (instRelease) begin
                    stateNext = RIdle;
                end
            end
            RDataBeat: begin
                if (dataRelease) begin
                    stateNext = RIdle;
                end
            end
            default: begin
                stateNext = RIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beatIdx <= '0;
        end else if (state != RInstBeats) begin
            beatIdx <= '0;
        end else if (beatTaken) begin
            beatIdx <= beatIdx + 1'b1;
        end
    end

    // Beats arrive in wrap order starting at the aligned address.
    always_ff @(posedge clk) begin
        if (beatTaken && !rLast) begin
            asmLine[beatIdx] <= rData;
        end
    end

endmodule

//--- design/writeEngine.sv
`timescale 1ns/100ps

module writeEngine import axiPkg::*, cpuPkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    dataBusy,
    input  dataReqT dataHeld,
    output logic    dataRelease,

    output logic    awValid,
    output axT      aw,
    input  logic    awReady,

    output logic    wValid,
    output wBeatT   w,
    input  logic    wReady,

    input  logic    bValid,
    output logic    bReady
);

    typedef enum logic [1:0] {
        WIdle,
        WDataBeat,
        WResp
    } wStateT;

    wStateT state;
    wStateT stateNext;

    assign awValid = (state == WIdle) && dataBusy && dataHeld.writeEn;

    always_comb begin
        aw.id    = IdData;
        aw.addr  = dataHeld.addr;
        aw.len   = LenSingle;
        aw.size  = SizeWord;
        aw.burst = BurstIncr;
    end

    // Single beat, so last is always set.
    always_comb begin
        w.data   = dataHeld.wData;
        w.strobe = dataHeld.strobe;
        w.last   = 1'b1;
    end

    assign wValid      = (state == WDataBeat);
    assign bReady      = (state == WResp);
    assign dataRelease = bReady && bValid;

    always_comb begin
        stateNext = state;
        case (state)
            WIdle: begin
                if (awValid && awReady) begin
                    stateNext = WDataBeat;
                end
            end
            WDataBeat: begin
                if (wValid && wReady) begin
                    stateNext = WResp;
                end
            end
            WResp: begin
                if (dataRelease) begin
                    stateNext = WIdle;
                end
            end
            default: begin
                stateNext = WIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WIdle;
        end else begin
            state <= stateNext;
        end
    end

endmodule

//--- design/busBridge.sv
`timescale 1ns/100ps

module busBridge import axiPkg::*, cpuPkg::*; (
    input  logic    clk,
    input  logic    rst,

    input  logic    instReqValid,
    input  instReqT instReq,
    output logic    instReqReady,
    output logic    instRespValid,
    output lineT    instLine,
    input  logic    instRespReady,

    input  logic    dataReqValid,
    input  dataReqT dataReq,
    output logic    dataReqReady,
    output logic    dataRespValid,
    output wordT    dataRdata,
    input  logic    dataRespReady,

    output logic    arValid,
    output axT      ar,
    input  logic    arReady,
    input  logic    rValid,
    input  wordT    rData,
    input  logic    rLast,
    output logic    rReady,

    output logic    awValid,
    output axT      aw,
    input  logic    awReady,
    output logic    wValid,
    output wBeatT   w,
    input  logic    wReady,
    input  logic    bValid,
    output logic    bReady
);

    logic    instBusy;
    instReqT instHeld;
    logic    instRelease;

    logic    dataBusy;
    dataReqT dataHeld;
    logic    rdDataRelease;
    logic    wrDataRelease;

    reqSlot #(.payloadT(instReqT)) instSlot (
        .clk          (clk),
        .rst          (rst),
        .reqValid     (instReqValid),
        .reqIn        (instReq),
        .reqReady     (instReqReady),
        .releasePulse (instRelease),
        .busy         (instBusy),
        .held         (instHeld)
    );

    // Only one engine owns the data slot at a time.
    reqSlot #(.payloadT(dataReqT)) dataSlot (
        .clk          (clk),
        .rst          (rst),
        .reqValid     (dataReqValid),
        .reqIn        (dataReq),
        .reqReady     (dataReqReady),
        .releasePulse (rdDataRelease || wrDataRelease),
        .busy         (dataBusy),
        .held         (dataHeld)
    );

    readEngine readEng (
        .clk           (clk),
        .rst           (rst),
        .instBusy      (instBusy),
        .instHeld      (instHeld),
        .instRelease   (instRelease),
        .dataBusy      (dataBusy),
        .dataHeld      (dataHeld),
        .dataRelease   (rdDataRelease),
        .arValid       (arValid),
        .ar            (ar),
        .arReady       (arReady),
        .rValid        (rValid),
        .rData         (rData),
        .rLast         (rLast),
        .rReady        (rReady),
        .instRespValid (instRespValid),
        .instLine      (instLine),
        .instRespReady (instRespReady),
        .dataRespValid (dataRespValid),
        .dataRdata     (dataRdata),
        .dataRespReady (dataRespReady)
    );

    writeEngine writeEng (
        .clk         (clk),
        .rst         (rst),
        .dataBusy    (dataBusy),
        .dataHeld    (dataHeld),
        .dataRelease (wrDataRelease),
        .awValid     (awValid),
        .aw          (aw),
        .awReady     (awReady),
        .wValid      (wValid),
        .w           (w),
        .wReady      (wReady),
        .bValid      (bValid),
        .bReady      (bReady)
    );

endmodule

//--- bench/bridgeChecker.sv
`timescale 1ns/100ps

module bridgeChecker import axiPkg::*, cpuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    instReqValid, instReqReady, instRespValid, instRespReady,
    input  instReqT instReq,
    input  lineT    instLine,
    input  logic    dataReqValid, dataReqReady, dataRespValid, dataRespReady,
    input  dataReqT dataReq,
    input  wordT    dataRdata,
    input  logic    arValid, arReady, awValid, awReady, wValid, wReady, bValid, bReady,
    input  logic    rValid, rReady,
    input  axT      ar, aw,
    input  wBeatT   w,
    output int      errors,
    output int      tests
);

    wordT    shadow [256];
    addrT    pcHeld;
    dataReqT dHeld;
    logic    instPend, dataPend, wrPend, wasReset, instWait, dataWait, bSeen;
    lineT    lastLine;
    wordT    lastWord;
    axT      expAw;
    wBeatT   expW;
    int      beats;
    int      errBase;

    function automatic wordT fillWord(int idx);
        return wordT'(idx) * 32'h9e3779b1 ^ 32'hc3a50f1e;
    endfunction

    // Expected line or word, taken from the shadow memory.
    function automatic lineT refResult(logic isInst, addrT a);
        lineT r;
        r = '0;
        if (isInst) begin
            for (int i = 0; i < BeatsPerLine; i++) begin
                r[32*i +: 32] = shadow[{a[9:4], 2'(i)}];
            end
        end else begin
            r[31:0] = shadow[a[9:2]];
        end
        return r;
    endfunction

    task automatic compare(string name, lineT expVal, lineT actVal);
        if (expVal !== actVal) begin
            errors++;
            $display("Fail %0t %s expected %h actual %h", $time, name, expVal, actVal);
        end
    endtask

    task automatic endTest(string what);
        tests++;
        $display("test %0d %s %s", tests, what, (errors == errBase) ? "ok" : "bad");
        errBase = errors;
    endtask

    initial begin
        errors = 0;
        tests = 0;
        errBase = 0;
        wasReset = 1'b0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fillWord(i);
        end
    end

    // Everything is sampled mid-cycle, so a valid/ready pair seen here completes next edge.
    always @(negedge clk) begin
        if (rst) begin
            instPend = 1'b0;
            dataPend = 1'b0;
            wrPend   = 1'b0;
            instWait = 1'b0;
            dataWait = 1'b0;
            bSeen    = 1'b0;
            beats    = 0;
            wasReset = 1'b1;
        end else begin
            if (wasReset) begin
                compare("{arValid,awValid,wValid,bReady,respValids,reqReadies}",
                    lineT'(8'b00000011), lineT'({arValid, awValid, wValid, bReady,
                    instRespValid, dataRespValid, instReqReady, dataReqReady}));
                endTest("reset state");
                wasReset = 1'b0;
            end
            if (instWait) begin
                compare("instRespValid", lineT'(1'b1), lineT'(instRespValid));
                compare("instLine", lastLine, instLine);    // Held under back-pressure.
            end
            if (dataWait) begin
                compare("dataRespValid", lineT'(1'b1), lineT'(dataRespValid));
                compare("dataRdata", lineT'(lastWord), lineT'(dataRdata));
            end
            if (bSeen) begin
                compare("dataReqReady", lineT'(1'b1), lineT'(dataReqReady));  // One cycle after B.
            end
            // A pending data read goes out before a pending fetch.
            if (arValid && arReady) begin
                if (dataPend) begin
                    compare("ar.id", lineT'(IdData), lineT'(ar.id));
                    compare("ar.len", lineT'(LenSingle), lineT'(ar.len));
                    compare("ar.addr", lineT'(dHeld.addr), lineT'(ar.addr));
                    dataPend = 1'b0;
                end else if (instPend) begin
                    compare("ar.id", lineT'(IdInst), lineT'(ar.id));
                    compare("ar.len", lineT'(LenLine), lineT'(ar.len));
                    compare("ar.burst", lineT'(BurstWrap), lineT'(ar.burst));
                    compare("ar.addr", lineT'({pcHeld[31:4], 4'h0}), lineT'(ar.addr));
                    instPend = 1'b0;
                end else begin
                    errors++;
                    $display("AR issued at %0t with no read request pending", $time);
                end
            end
            if (awValid && awReady) begin
                if (!wrPend) begin
                    errors++;
                    $display("AW issued at %0t with no write request pending", $time);
                end
                expAw = '{IdData, dHeld.addr, LenSingle, SizeWord, BurstIncr};
                compare("aw", lineT'(expAw), lineT'(aw));
                wrPend = 1'b0;
            end
            if (wValid && wReady) begin
                expW = '{dHeld.wData, dHeld.strobe, 1'b1};
                compare("w", lineT'(expW), lineT'(w));
            end
            if (rValid && rReady) begin
                beats++;
            end
            if (instRespValid && instRespReady) begin
                compare("instLine", refResult(1'b1, pcHeld), instLine);
                compare("rReady handshakes", lineT'(BeatsPerLine), lineT'(beats));
                beats = 0;
                endTest("fetch");
            end
            if (dataRespValid && dataRespReady) begin
                compare("dataRdata", refResult(1'b0, dHeld.addr), lineT'(dataRdata));
                compare("rReady handshakes", lineT'(1), lineT'(beats));
                beats = 0;
                endTest("data read");
            end
            if (bValid && bReady) begin
                for (int b = 0; b < 4; b++) begin
                    if (dHeld.strobe[b]) shadow[dHeld.addr[9:2]][8*b +: 8] = dHeld.wData[8*b +: 8];
                end
                endTest("data write");
            end
            if (instReqValid && instReqReady) begin
                pcHeld = instReq.pc;
                instPend = 1'b1;
            end
            if (dataReqValid && dataReqReady) begin
                dHeld = dataReq;
                dataPend = !dataReq.writeEn;
                wrPend = dataReq.writeEn;
            end
            instWait = instRespValid && !instRespReady;
            dataWait = dataRespValid && !dataRespReady;
            bSeen = bValid && bReady;
            lastLine = instLine;
            lastWord = dataRdata;
        end
    end

endmodule

//--- bench/bridgeTb.sv
`timescale 1ns/100ps

module bridgeTb import axiPkg::*, cpuPkg::*; ();

    logic    clk, rst;
    logic    instReqValid, instReqReady, instRespValid, instRespReady;
    instReqT instReq;
    lineT    instLine;
    logic    dataReqValid, dataReqReady, dataRespValid, dataRespReady;
    dataReqT dataReq;
    wordT    dataRdata;
    logic    arValid, arReady, rValid, rLast, rReady;
    logic    awValid, awReady, wValid, wReady, bValid, bReady;
    axT      ar, aw;
    wBeatT   w;
    wordT    rData;
    int      errors, tests, hangs;
    logic [31:0] rngState, stimRng, rnd;

    wordT mem [256];   // Slave memory.
    logic rdActive;
    addrT rdBase, wrAddr;
    lenT  rdLen, rdCnt;
    logic [1:0] wrPhase;

    busBridge u_dut (.*);
    bridgeChecker u_chk (.*);

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic wordT fillWord(int idx);
        return wordT'(idx) * 32'h9e3779b1 ^ 32'hc3a50f1e;
    endfunction

    function addrT nextAddr();
        stimRng = xorshift(stimRng);
        return stimRng & 32'h0000_03fc;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // AXI slave with random delays, plus random response readies.
    always @(posedge clk) begin
        rngState = xorshift(rngState);
        rnd = rngState;
        if (rst) begin
            {arReady, rValid, rLast, awReady, wReady, bValid, rdActive} <= '0;
            {instRespReady, dataRespReady, wrPhase} <= '0;
        end else begin
            instRespReady <= rnd[5] | rnd[6];
            dataRespReady <= rnd[7] | rnd[8];
            if (!rdActive) begin
                if (arValid && arReady) begin
                    {rdActive, arReady, rdBase, rdLen, rdCnt} <= {2'b10, ar.addr, ar.len, 4'd0};
                end else begin
                    arReady <= rnd[0];
                end
            end else if (rValid && rReady) begin
                rValid <= 1'b0;
                rdCnt <= rdCnt + 1'b1;
                if (rLast) rdActive <= 1'b0;
            end else if (!rValid && rnd[1]) begin
                rValid <= 1'b1;
                rData <= mem[{rdBase[9:4], 2'(rdBase[3:2] + rdCnt[1:0])}];   // Wraps in line.
                rLast <= (rdCnt == rdLen);
            end
            case (wrPhase)
                2'd0: begin
                    awReady <= rnd[2] && !(awValid && awReady);
                    if (awValid && awReady) {wrAddr, wrPhase} <= {aw.addr, 2'd1};
                end
                2'd1: begin
                    wReady <= rnd[3] && !(wValid && wReady);
                    if (wValid && wReady) begin
                        for (int b = 0; b < 4; b++) begin
                            if (w.strobe[b]) mem[wrAddr[9:2]][8*b +: 8] <= w.data[8*b +: 8];
                        end
                        wrPhase <= 2'd2;
                    end
                end
                default: begin
                    if (bValid && bReady) {bValid, wrPhase} <= {1'b0, 2'd0};
                    else if (!bValid) bValid <= rnd[4];
                end
            endcase
        end
    end

    task automatic waitUntil(int kind, string what);
        int n;
        logic hit;
        n = 0;
        hit = 1'b0;
        while (!hit && n < 400) begin
            @(posedge clk);
            n++;
            case (kind)
                0: hit = instReqValid && instReqReady;
                1: hit = dataReqValid && dataReqReady;
                2: hit = instRespValid && instRespReady;
                3: hit = dataRespValid && dataRespReady;
                default: hit = dataReqReady;
            endcase
        end
        if (!hit) begin
            hangs++;
            $display("timeout while waiting for %s", what);
        end
    endtask

    task automatic fetch(addrT pc);
        @(posedge clk);
        instReqValid <= 1'b1;
        instReq.pc <= pc;
        waitUntil(0, "fetch request accept");
        instReqValid <= 1'b0;
        waitUntil(2, "fetch response");
    endtask

    task automatic dataAccess(addrT a, wordT d, strobeT s, logic we);
        @(posedge clk);
        dataReqValid <= 1'b1;
        dataReq <= '{a, d, s, we};
        waitUntil(1, "data request accept");
        dataReqValid <= 1'b0;
        if (we) waitUntil(4, "data request ready after write");
        else waitUntil(3, "data read response");
    endtask

    // Both slots are free, so both requests land on the same edge.
    task automatic fetchAndRead(addrT pc, addrT a);
        @(posedge clk);
        {instReqValid, dataReqValid} <= 2'b11;
        instReq.pc <= pc;
        dataReq <= '{a, '0, '0, 1'b0};
        waitUntil(0, "paired request accept");
        {instReqValid, dataReqValid} <= 2'b00;
        waitUntil(3, "paired data response");
        waitUntil(2, "paired fetch response");
    endtask

    initial begin
        addrT a;
        rngState = 32'd65403;
        stimRng = xorshift(32'd65403);
        rst = 1'b1;
        hangs = 0;
        {instReqValid, dataReqValid, arReady, rValid, rLast} = '0;
        {awReady, wReady, bValid, instRespReady, dataRespReady} = '0;
        instReq = '0;
        dataReq = '0;
        rData = '0;
        for (int i = 0; i < 256; i++) mem[i] = fillWord(i);
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 4; i++) if (hangs == 0) fetch(nextAddr());
        for (int i = 0; i < 4; i++) if (hangs == 0) dataAccess(nextAddr(), '0, '0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            a = nextAddr();
            stimRng = xorshift(stimRng);
            if (hangs == 0) dataAccess(a, stimRng, stimRng[3:0], 1'b1);
            if (hangs == 0) dataAccess(a, '0, '0, 1'b0);   // Reads back the merged word.
        end
        for (int i = 0; i < 2; i++) if (hangs == 0) fetchAndRead(nextAddr(), nextAddr());
        repeat (4) @(posedge clk);
        $display("%0d tests run, %0d errors, %0d timeouts", tests, errors, hangs);
        if (errors == 0 && hangs == 0 && tests > 0) $display("all tests passed");
        else $display("tests failed");
        $finish;
    end

endmodule

//--- flist.f
design/axiPkg.sv
design/cpuPkg.sv
design/reqSlot.sv
design/readEngine.sv
design/writeEngine.sv
design/busBridge.sv
bench/bridgeChecker.sv
bench/bridgeTb.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the log.
verilator --binary --timing -f flist.f --top-module bridgeTb -o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
